// File: common/regblk_pkg.sv
package regblk_pkg;

  localparam int ADDR_WIDTH   = 16;
  localparam int DATA_WIDTH   = 32;
  localparam int STRB_WIDTH   = DATA_WIDTH / 8;
  localparam int OFFSET_WIDTH = 8;

  localparam logic [OFFSET_WIDTH-1:0] CTRL_OFFSET    = 8'h00;
  localparam logic [OFFSET_WIDTH-1:0] HWIN_OFFSET    = 8'h04;
  localparam logic [OFFSET_WIDTH-1:0] TRIGGER_OFFSET = 8'h08;
  localparam logic [OFFSET_WIDTH-1:0] EVENT_OFFSET   = 8'h0C;
  localparam logic [OFFSET_WIDTH-1:0] MASK_OFFSET    = 8'h10;

  // Control register layout.
  localparam int MODE_WIDTH = 4;
  localparam int GAIN_WIDTH = 4;
  localparam int MODE_LSB   = 0;
  localparam int GAIN_LSB   = MODE_LSB + MODE_WIDTH;
  localparam int ENABLE_BIT = GAIN_LSB + GAIN_WIDTH;
  localparam int CTRL_WIDTH = ENABLE_BIT + 1;

  localparam int HWIN_WIDTH = 8;

  // Trigger register layout.
  localparam int TRIG_WIDTH = 4;
  localparam int START_LSB  = 0;
  localparam int STOP_LSB   = START_LSB + TRIG_WIDTH;

  localparam int EVENT_COUNT = 4; // Same bit positions in EVENT and MASK.

  typedef enum logic [2:0] {
    REG_CTRL,
    REG_HWIN,
    REG_TRIGGER,
    REG_EVENT,
    REG_MASK,
    REG_NONE
  } reg_index_e;

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_SETUP,
    PH_ACCESS
  } apb_phase_e;

  // Expands the byte strobes into a bit mask over the data bus.
  function automatic logic [DATA_WIDTH-1:0] strb_to_mask(
    input logic [STRB_WIDTH-1:0] strb
  );
    logic [DATA_WIDTH-1:0] mask;
    mask = '0;
    for (int i = 0; i < STRB_WIDTH; i++) begin
      mask[8*i +: 8] = {8{strb[i]}};
    end
    return mask;
  endfunction

endpackage

// File: source/apb_access.sv
module apb_access #(
  parameter logic [regblk_pkg::ADDR_WIDTH-1:0] BASE_ADDRESS = 16'h1000
) (
  input  logic                              clk,
  input  logic                              i_rst_n,
  input  logic                              i_psel,
  input  logic                              i_penable,
  input  logic [regblk_pkg::ADDR_WIDTH-1:0] i_paddr,
  input  logic                              i_pwrite,
  input  logic [regblk_pkg::STRB_WIDTH-1:0] i_pstrb,
  input  logic [regblk_pkg::DATA_WIDTH-1:0] i_pwdata,
  output regblk_pkg::reg_index_e            o_reg_index,
  output logic                              o_access,
  output logic                              o_write,
  output logic [regblk_pkg::STRB_WIDTH-1:0] o_wstrb,
  output logic [regblk_pkg::DATA_WIDTH-1:0] o_wdata
);

  import regblk_pkg::*;

  apb_phase_e              phase_d;
  apb_phase_e              phase_q;
  logic [ADDR_WIDTH-1:0]   rel_addr;
  logic [OFFSET_WIDTH-1:0] offset;
  logic                    in_window;
  logic                    aligned;

  always_comb begin
    if (!i_psel) begin
      phase_d = PH_IDLE;
    end else if (!i_penable) begin
      phase_d = PH_SETUP;
    end else begin
      phase_d = PH_ACCESS;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      phase_q <= PH_IDLE;
    end else begin
      phase_q <= phase_d;
    end
  end

  assign rel_addr  = i_paddr - BASE_ADDRESS;
  assign offset    = rel_addr[OFFSET_WIDTH-1:0];
  assign in_window = (i_paddr >= BASE_ADDRESS) && (rel_addr[ADDR_WIDTH-1:OFFSET_WIDTH] == '0);
  assign aligned   = (i_paddr[1:0] == 2'b00);

  always_comb begin
    o_reg_index = REG_NONE;
    if (in_window && aligned) begin
      case (offset)
        CTRL_OFFSET:    o_reg_index = REG_CTRL;
        HWIN_OFFSET:    o_reg_index = REG_HWIN;
        TRIGGER_OFFSET: o_reg_index = REG_TRIGGER;
        EVENT_OFFSET:   o_reg_index = REG_EVENT;
        MASK_OFFSET:    o_reg_index = REG_MASK;
        default:        o_reg_index = REG_NONE;
      endcase
    end
  end

  // Only an access phase that follows a setup cycle reaches the registers.
  assign o_access = i_psel && i_penable && (phase_q == PH_SETUP);
  assign o_write  = i_pwrite;
  assign o_wstrb  = i_pwrite ? i_pstrb : '0; // Reads carry no strobes.
  assign o_wdata  = i_pwdata;

  a_penable_after_setup: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    (i_psel && $rose(i_penable)) |-> (phase_q == PH_SETUP)
  );

  a_addr_stable: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    (i_psel && i_penable) |-> ($stable(i_paddr) && $stable(i_pwrite))
  );

endmodule

// File: registers/ctrl_regs.sv
module ctrl_regs #(
  parameter logic [regblk_pkg::CTRL_WIDTH-1:0] CTRL_RESET = 9'h0C5
) (
  input  logic                              clk,
  input  logic                              i_rst_n,
  input  regblk_pkg::reg_index_e            i_reg_index,
  input  logic                              i_access,
  input  logic                              i_write,
  input  logic [regblk_pkg::STRB_WIDTH-1:0] i_wstrb,
  input  logic [regblk_pkg::DATA_WIDTH-1:0] i_wdata,
  input  logic [regblk_pkg::HWIN_WIDTH-1:0] i_hw_status,
  output logic [regblk_pkg::DATA_WIDTH-1:0] o_rdata,
  output logic [regblk_pkg::MODE_WIDTH-1:0] o_mode,
  output logic [regblk_pkg::GAIN_WIDTH-1:0] o_gain,
  output logic                              o_enable,
  output logic [regblk_pkg::TRIG_WIDTH-1:0] o_start,
  output logic [regblk_pkg::TRIG_WIDTH-1:0] o_stop
);

  import regblk_pkg::*;

  logic [DATA_WIDTH-1:0]   wmask;
  logic                    ctrl_we;
  logic                    trig_we;
  logic [CTRL_WIDTH-1:0]   ctrl_q;
  logic [CTRL_WIDTH-1:0]   ctrl_d;
  logic [2*TRIG_WIDTH-1:0] trig_bits;
  logic [TRIG_WIDTH-1:0]   start_q;
  logic [TRIG_WIDTH-1:0]   stop_q;

  assign wmask   = strb_to_mask(i_wstrb);
  assign ctrl_we = i_access && i_write && (i_reg_index == REG_CTRL);
  assign trig_we = i_access && i_write && (i_reg_index == REG_TRIGGER);

  // Bytes without a strobe keep their old value.
  assign ctrl_d = (ctrl_q & ~wmask[CTRL_WIDTH-1:0]) |
                  (i_wdata[CTRL_WIDTH-1:0] & wmask[CTRL_WIDTH-1:0]);

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ctrl_q <= CTRL_RESET;
    end else if (ctrl_we) begin
      ctrl_q <= ctrl_d;
    end
  end

  assign trig_bits = i_wdata[2*TRIG_WIDTH-1:0] & wmask[2*TRIG_WIDTH-1:0];

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      start_q <= '0;
      stop_q  <= '0;
    end else begin
      start_q <= trig_we ? trig_bits[START_LSB +: TRIG_WIDTH] : '0; // One-cycle pulse.
      stop_q  <= trig_we ? trig_bits[STOP_LSB +: TRIG_WIDTH] : '0;
    end
  end

  always_comb begin
    o_rdata = '0;
    case (i_reg_index)
      REG_CTRL: o_rdata[CTRL_WIDTH-1:0] = ctrl_q;
      REG_HWIN: o_rdata[HWIN_WIDTH-1:0] = i_hw_status;
      default:  o_rdata = '0; // TRIGGER always reads back as zero.
    endcase
  end

  assign o_mode   = ctrl_q[MODE_LSB +: MODE_WIDTH];
  assign o_gain   = ctrl_q[GAIN_LSB +: GAIN_WIDTH];
  assign o_enable = ctrl_q[ENABLE_BIT];
  assign o_start  = start_q;
  assign o_stop   = stop_q;

  // APB needs a setup cycle between accesses, so pulses never run back to back.
  a_pulse_single: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    ((o_start != '0) || (o_stop != '0)) |=> ((o_start == '0) && (o_stop == '0))
  );

endmodule

// File: registers/event_regs.sv
module event_regs (
  input  logic                               clk,
  input  logic                               i_rst_n,
  input  regblk_pkg::reg_index_e             i_reg_index,
  input  logic                               i_access,
  input  logic                               i_write,
  input  logic [regblk_pkg::STRB_WIDTH-1:0]  i_wstrb,
  input  logic [regblk_pkg::DATA_WIDTH-1:0]  i_wdata,
  input  logic [regblk_pkg::EVENT_COUNT-1:0] i_event_set,
  output logic [regblk_pkg::DATA_WIDTH-1:0]  o_rdata,
  output logic                               o_irq
);

  import regblk_pkg::*;

  logic [DATA_WIDTH-1:0]  wmask;
  logic                   event_we;
  logic                   mask_we;
  logic [EVENT_COUNT-1:0] wbits;
  logic [EVENT_COUNT-1:0] clear;
  logic [EVENT_COUNT-1:0] flags_q;
  logic [EVENT_COUNT-1:0] flags_d;
  logic [EVENT_COUNT-1:0] mask_q;

  assign wmask    = strb_to_mask(i_wstrb);
  assign wbits    = i_wdata[EVENT_COUNT-1:0] & wmask[EVENT_COUNT-1:0];
  assign event_we = i_access && i_write && (i_reg_index == REG_EVENT);
  assign mask_we  = i_access && i_write && (i_reg_index == REG_MASK);

  assign clear   = event_we ? wbits : '0;
  assign flags_d = (flags_q & ~clear) | i_event_set; // A hardware set beats a clear.

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      flags_q <= '0;
    end else begin
      flags_q <= flags_d;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mask_q <= '0;
    end else if (mask_we) begin
      mask_q <= (mask_q & ~wmask[EVENT_COUNT-1:0]) | wbits;
    end
  end

  always_comb begin
    o_rdata = '0;
    case (i_reg_index)
      REG_EVENT: o_rdata[EVENT_COUNT-1:0] = flags_q;
      REG_MASK:  o_rdata[EVENT_COUNT-1:0] = mask_q;
      default:   o_rdata = '0;
    endcase
  end

  assign o_irq = |(flags_q & mask_q);

  // Every set request must show up as a flag in the following cycle.
  a_set_not_lost: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    (i_event_set != '0) |=> ((flags_q & $past(i_event_set)) == $past(i_event_set))
  );

endmodule

// File: source/apb_response.sv
module apb_response #(
  parameter logic [regblk_pkg::DATA_WIDTH-1:0] DEFAULT_READ_DATA = 32'hDEAD_BEAF
) (
  input  logic                              i_psel,
  input  logic                              i_penable,
  input  regblk_pkg::reg_index_e            i_reg_index,
  input  logic                              i_write,
  input  logic [regblk_pkg::DATA_WIDTH-1:0] i_ctrl_rdata,
  input  logic [regblk_pkg::DATA_WIDTH-1:0] i_event_rdata,
  output logic                              o_pready,
  output logic [regblk_pkg::DATA_WIDTH-1:0] o_prdata,
  output logic                              o_pslverr
);

  import regblk_pkg::*;

  logic [DATA_WIDTH-1:0] rdata;
  logic                  error;

  // Every access phase completes at once.
  assign o_pready = i_psel && i_penable;

  always_comb begin
    case (i_reg_index)
      REG_CTRL,
      REG_HWIN,
      REG_TRIGGER: rdata = i_ctrl_rdata;
      REG_EVENT,
      REG_MASK:    rdata = i_event_rdata;
      default:     rdata = DEFAULT_READ_DATA;
    endcase
  end

  // Unmapped addresses and writes to the status view are refused.
  always_comb begin
    error = 1'b0;
    if (i_reg_index == REG_NONE) begin
      error = 1'b1;
    end else if ((i_reg_index == REG_HWIN) && i_write) begin
      error = 1'b1;
    end
  end

  assign o_prdata  = i_write ? '0 : rdata;
  assign o_pslverr = o_pready && error; // Only meaningful in the access phase.

endmodule

// File: source/apb_regblk.sv
module apb_regblk #(
  parameter logic [regblk_pkg::ADDR_WIDTH-1:0] BASE_ADDRESS      = 16'h1000,
  parameter logic [regblk_pkg::DATA_WIDTH-1:0] DEFAULT_READ_DATA = 32'hDEAD_BEAF,
  parameter logic [regblk_pkg::CTRL_WIDTH-1:0] CTRL_RESET        = 9'h0C5
) (
  input  logic                               clk,
  input  logic                               i_rst_n,
  input  logic                               i_psel,
  input  logic                               i_penable,
  input  logic [regblk_pkg::ADDR_WIDTH-1:0]  i_paddr,
  input  logic                               i_pwrite,
  input  logic [regblk_pkg::STRB_WIDTH-1:0]  i_pstrb,
  input  logic [regblk_pkg::DATA_WIDTH-1:0]  i_pwdata,
  input  logic [regblk_pkg::HWIN_WIDTH-1:0]  i_hw_status,
  input  logic [regblk_pkg::EVENT_COUNT-1:0] i_event_set,
  output logic                               o_pready,
  output logic [regblk_pkg::DATA_WIDTH-1:0]  o_prdata,
  output logic                               o_pslverr,
  output logic [regblk_pkg::MODE_WIDTH-1:0]  o_mode,
  output logic [regblk_pkg::GAIN_WIDTH-1:0]  o_gain,
  output logic                               o_enable,
  output logic [regblk_pkg::TRIG_WIDTH-1:0]  o_start,
  output logic [regblk_pkg::TRIG_WIDTH-1:0]  o_stop,
  output logic                               o_irq
);

  import regblk_pkg::*;

  reg_index_e            reg_index;
  logic                  access;
  logic                  write;
  logic [STRB_WIDTH-1:0] wstrb;
  logic [DATA_WIDTH-1:0] wdata;
  logic [DATA_WIDTH-1:0] ctrl_rdata;
  logic [DATA_WIDTH-1:0] event_rdata;

  apb_access #(
    .BASE_ADDRESS (BASE_ADDRESS )
  ) u_apb_access (
    .clk          (clk          ),
    .i_rst_n      (i_rst_n      ),
    .i_psel       (i_psel       ),
    .i_penable    (i_penable    ),
    .i_paddr      (i_paddr      ),
    .i_pwrite     (i_pwrite     ),
    .i_pstrb      (i_pstrb      ),
    .i_pwdata     (i_pwdata     ),
    .o_reg_index  (reg_index    ),
    .o_access     (access       ),
    .o_write      (write        ),
    .o_wstrb      (wstrb        ),
    .o_wdata      (wdata        )
  );

  ctrl_regs #(
    .CTRL_RESET   (CTRL_RESET   )
  ) u_ctrl_regs (
    .clk          (clk          ),
    .i_rst_n      (i_rst_n      ),
    .i_reg_index  (reg_index    ),
    .i_access     (access       ),
    .i_write      (write        ),
    .i_wstrb      (wstrb        ),
    .i_wdata      (wdata        ),
    .i_hw_status  (i_hw_status  ),
    .o_rdata      (ctrl_rdata   ),
    .o_mode       (o_mode       ),
    .o_gain       (o_gain       ),
    .o_enable     (o_enable     ),
    .o_start      (o_start      ),
    .o_stop       (o_stop       )
  );

  event_regs u_event_regs (
    .clk          (clk          ),
    .i_rst_n      (i_rst_n      ),
    .i_reg_index  (reg_index    ),
    .i_access     (access       ),
    .i_write      (write        ),
    .i_wstrb      (wstrb        ),
    .i_wdata      (wdata        ),
    .i_event_set  (i_event_set  ),
    .o_rdata      (event_rdata  ),
    .o_irq        (o_irq        )
  );

  apb_response #(
    .DEFAULT_READ_DATA  (DEFAULT_READ_DATA  )
  ) u_apb_response (
    .i_psel             (i_psel             ),
    .i_penable          (i_penable          ),
    .i_reg_index        (reg_index          ),
    .i_write            (write              ),
    .i_ctrl_rdata       (ctrl_rdata         ),
    .i_event_rdata      (event_rdata        ),
    .o_pready           (o_pready           ),
    .o_prdata           (o_prdata           ),
    .o_pslverr          (o_pslverr          )
  );

endmodule

// File: tests/apb_regblk_tb.sv
module apb_regblk_tb;

  import regblk_pkg::*;

  localparam logic [ADDR_WIDTH-1:0] BASE        = 16'h1000;
  localparam logic [DATA_WIDTH-1:0] DEFAULT_RD  = 32'hDEAD_BEAF;
  localparam logic [CTRL_WIDTH-1:0] CTRL_INIT   = 9'h0C5;
  localparam logic [ADDR_WIDTH-1:0] CTRL_ADDR   = BASE + {8'h00, CTRL_OFFSET};
  localparam logic [ADDR_WIDTH-1:0] HWIN_ADDR   = BASE + {8'h00, HWIN_OFFSET};
  localparam logic [ADDR_WIDTH-1:0] TRIG_ADDR   = BASE + {8'h00, TRIGGER_OFFSET};
  localparam logic [ADDR_WIDTH-1:0] EVENT_ADDR  = BASE + {8'h00, EVENT_OFFSET};
  localparam logic [ADDR_WIDTH-1:0] MASK_ADDR   = BASE + {8'h00, MASK_OFFSET};
  localparam int                    READY_LIMIT = 8;

  logic                   clk;
  logic                   rst_n;
  logic                   psel;
  logic                   penable;
  logic [ADDR_WIDTH-1:0]  paddr;
  logic                   pwrite;
  logic [STRB_WIDTH-1:0]  pstrb;
  logic [DATA_WIDTH-1:0]  pwdata;
  logic [HWIN_WIDTH-1:0]  hw_status;
  logic [EVENT_COUNT-1:0] event_set;
  logic                   pready;
  logic [DATA_WIDTH-1:0]  prdata;
  logic                   pslverr;
  logic [MODE_WIDTH-1:0]  o_mode;
  logic [GAIN_WIDTH-1:0]  o_gain;
  logic                   o_enable;
  logic [TRIG_WIDTH-1:0]  o_start;
  logic [TRIG_WIDTH-1:0]  o_stop;
  logic                   o_irq;

  logic [CTRL_WIDTH-1:0]  exp_ctrl;
  logic [EVENT_COUNT-1:0] exp_mask;
  logic [EVENT_COUNT-1:0] exp_flags;
  logic [TRIG_WIDTH-1:0]  exp_start;
  logic [TRIG_WIDTH-1:0]  exp_stop;
  logic [DATA_WIDTH-1:0]  wbits;
  logic [EVENT_COUNT-1:0] clr_bits;
  logic                   wr_access;
  logic                   trig_hit;
  logic [DATA_WIDTH-1:0]  rd_data;
  logic                   rd_err;
  logic [DATA_WIDTH-1:0]  rnd;
  logic [DATA_WIDTH-1:0]  rnd_strb;
  string                  test_name;
  int                     seed;

  apb_regblk #(
    .BASE_ADDRESS      (BASE      ),
    .DEFAULT_READ_DATA (DEFAULT_RD),
    .CTRL_RESET        (CTRL_INIT )
  ) i_apb_regblk (
    .clk (clk), .i_rst_n (rst_n), .i_psel (psel), .i_penable (penable),
    .i_paddr (paddr), .i_pwrite (pwrite), .i_pstrb (pstrb), .i_pwdata (pwdata),
    .i_hw_status (hw_status), .i_event_set (event_set), .o_pready (pready),
    .o_prdata (prdata), .o_pslverr (pslverr), .o_mode (o_mode), .o_gain (o_gain),
    .o_enable (o_enable), .o_start (o_start), .o_stop (o_stop), .o_irq (o_irq)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  function automatic logic [DATA_WIDTH-1:0] merge_bytes(
    input logic [DATA_WIDTH-1:0] old_val,
    input logic [DATA_WIDTH-1:0] new_val,
    input logic [STRB_WIDTH-1:0] strb
  );
    logic [DATA_WIDTH-1:0] res;
    res = old_val;
    for (int b = 0; b < STRB_WIDTH; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign wr_access = psel && penable && pwrite;
  assign wbits     = merge_bytes('0, pwdata, pstrb); // Written bits under the strobes.
  assign trig_hit  = wr_access && (paddr == TRIG_ADDR);
  assign clr_bits  = (wr_access && (paddr == EVENT_ADDR)) ? wbits[EVENT_COUNT-1:0] : '0;

  // Pulses follow a TRIGGER write by one cycle, and a hardware set beats a clear.
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_start <= '0;
      exp_stop  <= '0;
      exp_flags <= '0;
    end else begin
      exp_start <= trig_hit ? wbits[START_LSB +: TRIG_WIDTH] : '0;
      exp_stop  <= trig_hit ? wbits[STOP_LSB +: TRIG_WIDTH] : '0;
      exp_flags <= (exp_flags & ~clr_bits) | event_set;
    end
  end

  a_pready: assert property (@(posedge clk) disable iff (!rst_n) pready == (psel && penable))
    else begin
      $display("MISMATCH %s pready expected %0b actual %0b", test_name, psel && penable, pready);
      $display("sim failed");
      $fatal(1, "The pready check failed.");
    end

  a_ctrl_out: assert property (@(posedge clk) disable iff (!rst_n)
    {o_enable, o_gain, o_mode} == exp_ctrl)
    else begin
      $display("MISMATCH %s control outputs expected 0x%03h actual 0x%03h", test_name,
               exp_ctrl, {o_enable, o_gain, o_mode});
      $display("sim failed");
      $fatal(1, "The control output check failed.");
    end

  a_trigger: assert property (@(posedge clk) disable iff (!rst_n)
    (o_start == exp_start) && (o_stop == exp_stop))
    else begin
      $display("MISMATCH %s stop,start expected 0x%02h actual 0x%02h", test_name,
               {exp_stop, exp_start}, {o_stop, o_start});
      $display("sim failed");
      $fatal(1, "The trigger pulse check failed.");
    end

  a_irq: assert property (@(posedge clk) disable iff (!rst_n) o_irq == |(exp_flags & exp_mask))
    else begin
      $display("MISMATCH %s o_irq expected %0b actual %0b", test_name,
               |(exp_flags & exp_mask), o_irq);
      $display("sim failed");
      $fatal(1, "The interrupt check failed.");
    end

  task automatic check_equal(input string what, input logic [DATA_WIDTH-1:0] expected,
                             input logic [DATA_WIDTH-1:0] actual);
    assert (expected == actual) else begin
      $display("MISMATCH %s %s expected 0x%08h actual 0x%08h", test_name, what, expected, actual);
      $display("sim failed");
      $fatal(1, "A register check failed.");
    end
  endtask

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    #1;
    while (!pready) begin
      if (cycles == READY_LIMIT) begin
        $display("Timeout in %s, pready stayed low for %0d cycles.", test_name, READY_LIMIT);
        $display("sim failed");
        $fatal(1, "Gave up waiting for pready.");
      end
      @(negedge clk);
      #1;
      cycles++;
    end
  endtask

  // One setup cycle, then an access cycle that ends when pready is seen.
  task automatic apb_transfer(input logic wr, input logic [ADDR_WIDTH-1:0] addr,
                              input logic [DATA_WIDTH-1:0] data,
                              input logic [STRB_WIDTH-1:0] strb);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    pstrb   = wr ? strb : '0;
    @(negedge clk);
    penable = 1'b1;
    wait_ready();
    rd_data = prdata;
    rd_err  = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data,
                           input logic [STRB_WIDTH-1:0] strb, input logic exp_err);
    logic [DATA_WIDTH-1:0] merged;
    apb_transfer(1'b1, addr, data, strb);
    check_equal("pslverr", {31'b0, exp_err}, {31'b0, rd_err});
    if (addr == CTRL_ADDR) begin
      merged   = merge_bytes({23'b0, exp_ctrl}, data, strb);
      exp_ctrl = merged[CTRL_WIDTH-1:0];
    end else if (addr == MASK_ADDR) begin
      merged   = merge_bytes({28'b0, exp_mask}, data, strb);
      exp_mask = merged[EVENT_COUNT-1:0];
    end
  endtask

  task automatic apb_read(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] expected,
                          input logic exp_err);
    apb_transfer(1'b0, addr, '0, '0);
    check_equal("pslverr", {31'b0, exp_err}, {31'b0, rd_err});
    check_equal("prdata", expected, rd_data);
  endtask

  task automatic pulse_event(input logic [EVENT_COUNT-1:0] bits);
    @(negedge clk);
    event_set = bits;
    @(negedge clk);
    event_set = '0;
  endtask

  initial begin
    seed      = 10612;
    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    paddr     = '0;
    pwrite    = 1'b0;
    pstrb     = '0;
    pwdata    = '0;
    hw_status = '0;
    event_set = '0;
    exp_ctrl  = CTRL_INIT;
    exp_mask  = '0;
    test_name = "reset";
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    check_equal("start,stop,irq", '0, {23'b0, o_start, o_stop, o_irq});
    apb_read(CTRL_ADDR, {23'b0, CTRL_INIT}, 1'b0);
    apb_read(EVENT_ADDR, '0, 1'b0);
    apb_read(MASK_ADDR, '0, 1'b0);

    test_name = "control";
    repeat (10) begin
      rnd      = $random(seed);
      rnd_strb = $random(seed);
      apb_write(CTRL_ADDR, rnd, rnd_strb[STRB_WIDTH-1:0], 1'b0);
      apb_read(CTRL_ADDR, {23'b0, exp_ctrl}, 1'b0);
    end

    test_name = "hwin";
    repeat (4) begin
      rnd       = $random(seed);
      hw_status = rnd[HWIN_WIDTH-1:0];
      apb_read(HWIN_ADDR, {24'b0, hw_status}, 1'b0);
      apb_write(HWIN_ADDR, ~rnd, 4'hF, 1'b1);
      apb_read(HWIN_ADDR, {24'b0, hw_status}, 1'b0);
    end

    test_name = "trigger";
    apb_write(TRIG_ADDR, 32'h0000_00A5, 4'h1, 1'b0);
    repeat (6) begin
      rnd      = $random(seed);
      rnd_strb = $random(seed);
      apb_write(TRIG_ADDR, rnd, rnd_strb[STRB_WIDTH-1:0], 1'b0);
      apb_read(TRIG_ADDR, '0, 1'b0);
    end

    test_name = "events";
    apb_write(MASK_ADDR, 32'h5, 4'hF, 1'b0);
    pulse_event(4'b0011);
    apb_read(EVENT_ADDR, {28'b0, exp_flags}, 1'b0);
    apb_write(EVENT_ADDR, 32'h1, 4'hF, 1'b0);
    apb_read(EVENT_ADDR, {28'b0, exp_flags}, 1'b0);
    event_set = 4'b0010; // Set and clear of the same flag meet here.
    apb_write(EVENT_ADDR, 32'h2, 4'hF, 1'b0);
    event_set = '0;
    apb_read(EVENT_ADDR, {28'b0, exp_flags}, 1'b0);
    apb_write(EVENT_ADDR, 32'hF, 4'hF, 1'b0);
    apb_read(EVENT_ADDR, {28'b0, exp_flags}, 1'b0);
    repeat (6) begin
      rnd = $random(seed);
      apb_write(MASK_ADDR, rnd, 4'hF, 1'b0);
      pulse_event(rnd[7:4]);
      apb_read(EVENT_ADDR, {28'b0, exp_flags}, 1'b0);
      apb_write(EVENT_ADDR, rnd, rnd[11:8], 1'b0);
      apb_read(MASK_ADDR, {28'b0, exp_mask}, 1'b0);
    end

    test_name = "errors";
    apb_read(16'h0FFC, DEFAULT_RD, 1'b1);
    apb_read(16'h1100, DEFAULT_RD, 1'b1);
    apb_read(16'h1002, DEFAULT_RD, 1'b1);
    apb_read(16'h1014, DEFAULT_RD, 1'b1);
    apb_read(16'h10FC, DEFAULT_RD, 1'b1);
    apb_write(16'h1018, $random(seed), 4'hF, 1'b1);
    apb_read(CTRL_ADDR, {23'b0, exp_ctrl}, 1'b0);

    $display("sim passed");
    $finish;
  end

endmodule

// File: apb_regblk.f
common/regblk_pkg.sv
source/apb_access.sv
registers/ctrl_regs.sv
registers/event_regs.sv
source/apb_response.sv
source/apb_regblk.sv
tests/apb_regblk_tb.sv

// File: run.sh
#!/bin/sh
# Builds the APB register block testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module apb_regblk_tb \
  -f apb_regblk.f \
  -o sim_apb_regblk
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status."
  exit "$status"
fi

./obj_dir/sim_apb_regblk
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation ended with status $status."
  exit "$status"
fi

echo "Simulation ended normally."
exit 0
